//--- include/unpack_defines.svh
/*
 * Width and depth constants for the bit-stream unpacker.
 * Included by the package and by every RTL file that sizes a port or a store.
 */
`ifndef UNPACK_DEFINES_SVH
`define UNPACK_DEFINES_SVH

// Input word width in bits
`define UNPACK_WORD_W 32

// Store depth in words, a power of two
`define UNPACK_WORDS 32

// Requested length, 0 to 15
`define UNPACK_LEN_W 4

// Widest field that can be delivered
`define UNPACK_FIELD_W 15

// Fill level in bits, must hold UNPACK_WORDS * UNPACK_WORD_W
`define UNPACK_LEVEL_W 11

`endif

//--- rtl/unpack_pkg.sv
/*
 * Shared types of the bit-stream unpacker: words, requests, fields and the
 * register port. Users refer to them as unpack_pkg::name.
 */
`default_nettype none

`include "unpack_defines.svh"

package unpack_pkg;

	typedef logic [`UNPACK_WORD_W-1:0] word_t;

	// Delivered-field counter
	typedef logic [15:0] count_t;

	typedef struct packed {
		logic [`UNPACK_LEN_W-1:0] len;
	} field_req_t;

	// Data bits at or above len are zero once the field leaves the aligner
	typedef struct packed {
		logic [`UNPACK_FIELD_W-1:0] data;
		logic [`UNPACK_LEN_W-1:0]   len;
	} field_t;

	typedef struct packed {
		logic [`UNPACK_WORD_W-4:0] rsvd;
		logic                      flush;
		logic                      msb_first;
		logic                      enable;
	} ctrl_t;

	typedef struct packed {
		logic [`UNPACK_WORD_W-$bits(count_t)-`UNPACK_LEVEL_W-1:0] rsvd;
		count_t                                              count;
		logic [`UNPACK_LEVEL_W-1:0]                          level;
	} status_t;

	// Address 0 reads as control, address 1 as status
	typedef union packed {
		ctrl_t   ctrl_view;
		status_t status_view;
	} reg_word_u;

	typedef struct packed {
		logic      we;
		logic      addr;
		reg_word_u wdata;
	} reg_req_t;

endpackage

`default_nettype wire

//--- rtl/bit_buffer.sv
/*
 * Circular bit store of the unpacker. Words are written at a word pointer,
 * fields are sliced at a bit pointer, and the fill level gates both handshakes.
 */
`timescale 1ns/1ps
`default_nettype none

`include "unpack_defines.svh"

module bit_buffer #(
	parameter int words = `UNPACK_WORDS
) (
	input  logic                       clk,
	input  logic                       rst,

	input  logic                       in_valid,
	input  unpack_pkg::word_t          in_data,
	output logic                       in_ready,

	input  logic                       req_valid,
	input  unpack_pkg::field_req_t     req,
	output logic                       req_ready,

	input  unpack_pkg::ctrl_t          ctrl,
	input  logic                       advance,

	output logic                       raw_valid,
	output unpack_pkg::field_t         raw_field,
	output logic [`UNPACK_LEVEL_W-1:0] level
);

	localparam int word_w     = `UNPACK_WORD_W;
	localparam int field_w    = `UNPACK_FIELD_W;
	localparam int level_w    = `UNPACK_LEVEL_W;
	localparam int store_bits = words * word_w;
	localparam int wr_ptr_w   = $clog2(words);
	localparam int rd_ptr_w   = $clog2(store_bits);

	// One extra word past the end mirrors word 0
	logic [store_bits+word_w-1:0] store;

	logic [wr_ptr_w-1:0] wr_ptr;
	logic [rd_ptr_w-1:0] rd_ptr;

	logic                in_fire;
	logic                req_fire;
	logic [level_w-1:0]  level_add;
	logic [level_w-1:0]  level_sub;

	//////////////////////////////////////////////////
	// Handshakes
	//////////////////////////////////////////////////

	// A full word of space must be free, so nothing unread is overwritten
	assign in_ready  = !ctrl.flush && (level <= level_w'(store_bits - word_w));
	assign req_ready = ctrl.enable && advance && (level >= level_w'(req.len));

	assign in_fire  = in_valid && in_ready;
	assign req_fire = req_valid && req_ready;

	//////////////////////////////////////////////////
	// Word store
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (in_fire)
		begin
			store[wr_ptr*word_w +: word_w] <= in_data;
			// Mirror copy lets a field that crosses the end be read in one slice
			if (wr_ptr == '0)
			begin
				store[store_bits +: word_w] <= in_data;
			end
		end
	end

	//////////////////////////////////////////////////
	// Pointers and fill level
	//////////////////////////////////////////////////

	assign level_add = in_fire ? level_w'(word_w) : '0;
	assign level_sub = req_fire ? level_w'(req.len) : '0;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end
		else if (ctrl.flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end
		else
		begin
			if (in_fire)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			// Both pointers wrap on their own at the end of the store
			if (req_fire)
			begin
				rd_ptr <= rd_ptr + rd_ptr_w'(req.len);
			end
			level <= level + level_add - level_sub;
		end
	end

	//////////////////////////////////////////////////
	// Raw field
	//////////////////////////////////////////////////

	// Unmasked slice, the aligner's first stage registers it
	assign raw_valid = req_fire;

	always_comb
	begin
		raw_field.data = store[rd_ptr +: field_w];
		raw_field.len  = req.len;
	end

endmodule

`default_nettype wire

//--- rtl/field_align.sv
/*
 * Two-stage output pipeline. Stage 1 clears bits above the length, stage 2
 * optionally reverses the field. Both stages hold while the output is stalled.
 */
`timescale 1ns/1ps
`default_nettype none

`include "unpack_defines.svh"

module field_align (
	input  logic               clk,
	input  logic               rst,
	input  logic               raw_valid,
	input  unpack_pkg::field_t raw_field,
	input  logic               msb_first,
	output logic               advance,
	output logic               out_valid,
	output unpack_pkg::field_t out_field,
	input  logic               out_ready,
	output logic               delivered
);

	localparam int field_w = `UNPACK_FIELD_W;

	logic               s1_valid;
	unpack_pkg::field_t s1_field;
	logic               stall;
	logic [field_w-1:0] masked;
	logic [field_w-1:0] reversed;

	assign stall     = out_valid && !out_ready;
	assign advance   = !stall;
	assign delivered = out_valid && out_ready;

	// Keep only bits below len
	always_comb
	begin
		for (int i = 0; i < field_w; i++)
		begin
			masked[i] = raw_field.data[i] && (i < int'(raw_field.len));
		end
	end

	// Stream bit i lands on field bit len-1-i
	always_comb
	begin
		reversed = '0;
		for (int i = 0; i < field_w; i++)
		begin
			if (i < int'(s1_field.len))
			begin
				reversed[i] = s1_field.data[int'(s1_field.len) - 1 - i];
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			s1_valid  <= 1'b0;
			out_valid <= 1'b0;
		end
		else if (advance)
		begin
			s1_valid  <= raw_valid;
			out_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			s1_field.data  <= masked;
			s1_field.len   <= raw_field.len;
			out_field.data <= msb_first ? reversed : s1_field.data;
			out_field.len  <= s1_field.len;
		end
	end

endmodule

`default_nettype wire

//--- rtl/unpack_regs.sv
/*
 * Control and status registers. Address 0 holds enable and bit order and
 * takes the flush command, address 1 reports level and delivered fields.
 */
`timescale 1ns/1ps
`default_nettype none

`include "unpack_defines.svh"

module unpack_regs (
	input  logic                       clk,
	input  logic                       rst,
	input  unpack_pkg::reg_req_t       reg_req,
	output unpack_pkg::reg_word_u      reg_rdata,
	output unpack_pkg::ctrl_t          ctrl,
	input  logic [`UNPACK_LEVEL_W-1:0] level,
	input  logic                       delivered
);

	logic                enable_q;
	logic                msb_first_q;
	unpack_pkg::count_t  count_q;
	logic                ctrl_we;
	logic                stat_we;

	assign ctrl_we = reg_req.we && !reg_req.addr;
	assign stat_we = reg_req.we && reg_req.addr;

	//////////////////////////////////////////////////
	// Register state
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			enable_q    <= 1'b0;
			msb_first_q <= 1'b0;
			count_q     <= '0;
		end
		else
		begin
			if (ctrl_we)
			begin
				enable_q    <= reg_req.wdata.ctrl_view.enable;
				msb_first_q <= reg_req.wdata.ctrl_view.msb_first;
			end
			// Any write to status clears the counter
			if (stat_we)
			begin
				count_q <= '0;
			end
			else if (delivered)
			begin
				count_q <= count_q + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Datapath control and read back
	//////////////////////////////////////////////////

	// Flush is a pulse for the write cycle only
	always_comb
	begin
		ctrl           = '0;
		ctrl.enable    = enable_q;
		ctrl.msb_first = msb_first_q;
		ctrl.flush     = ctrl_we && reg_req.wdata.ctrl_view.flush;
	end

	always_comb
	begin
		reg_rdata = '0;
		if (reg_req.addr)
		begin
			reg_rdata.status_view.level = level;
			reg_rdata.status_view.count = count_q;
		end
		else
		begin
			reg_rdata.ctrl_view.enable    = enable_q;
			reg_rdata.ctrl_view.msb_first = msb_first_q;
		end
	end

endmodule

`default_nettype wire

//--- rtl/bit_unpacker.sv
/*
 * Top level of the bit-stream unpacker. Connects the bit store, the
 * output aligner and the register block.
 */
`timescale 1ns/1ps
`default_nettype none

`include "unpack_defines.svh"

module bit_unpacker (
	input  logic                   clk,
	input  logic                   rst,

	input  logic                   in_valid,
	input  unpack_pkg::word_t      in_data,
	output logic                   in_ready,

	input  logic                   req_valid,
	input  unpack_pkg::field_req_t req,
	output logic                   req_ready,

	output logic                   out_valid,
	output unpack_pkg::field_t     out_field,
	input  logic                   out_ready,

	input  unpack_pkg::reg_req_t   reg_req,
	output unpack_pkg::reg_word_u  reg_rdata
);

	unpack_pkg::ctrl_t          ctrl;
	unpack_pkg::field_t         raw_field;
	logic                       raw_valid;
	logic                       advance;
	logic                       delivered;
	logic [`UNPACK_LEVEL_W-1:0] level;

	unpack_regs i_regs (
		.clk       (clk),
		.rst       (rst),
		.reg_req   (reg_req),
		.reg_rdata (reg_rdata),
		.ctrl      (ctrl),
		.level     (level),
		.delivered (delivered)
	);

	bit_buffer #(
		.words (`UNPACK_WORDS)
	) i_buffer (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_ready  (in_ready),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.ctrl      (ctrl),
		.advance   (advance),
		.raw_valid (raw_valid),
		.raw_field (raw_field),
		.level     (level)
	);

	field_align i_align (
		.clk       (clk),
		.rst       (rst),
		.raw_valid (raw_valid),
		.raw_field (raw_field),
		.msb_first (ctrl.msb_first),
		.advance   (advance),
		.out_valid (out_valid),
		.out_field (out_field),
		.out_ready (out_ready),
		.delivered (delivered)
	);

endmodule

`default_nettype wire

//--- bench/bit_unpacker_properties.sv
/*
 * Protocol properties of the unpacker, bound to the top level.
 * Covers output stall stability, field masking and the fill-level guards.
 */
`timescale 1ns/1ps
`default_nettype none

`include "unpack_defines.svh"

module bit_unpacker_properties (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       in_ready,
	input  logic                       req_ready,
	input  unpack_pkg::field_req_t     req,
	input  logic                       out_valid,
	input  logic                       out_ready,
	input  unpack_pkg::field_t         out_field,
	input  logic [`UNPACK_LEVEL_W-1:0] level
);

	localparam int level_w  = `UNPACK_LEVEL_W;
	localparam int max_fill = `UNPACK_WORDS * `UNPACK_WORD_W - `UNPACK_WORD_W;

	// Stalled output holds valid and payload
	stall_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_field))
		else $error("out_valid or out_field changed while stalled");

	// Nothing above the length leaks out
	upper_zero: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> ((out_field.data >> out_field.len) == '0))
		else $error("out_field has data bits at or above its length");

	req_guard: assert property (@(posedge clk) disable iff (rst)
		req_ready |-> (level >= level_w'(req.len)))
		else $error("req_ready high with too few bits stored");

	in_guard: assert property (@(posedge clk) disable iff (rst)
		in_ready |-> (level <= level_w'(max_fill)))
		else $error("in_ready high with less than one word free");

endmodule

bind bit_unpacker bit_unpacker_properties i_props (
	.clk       (clk),
	.rst       (rst),
	.in_ready  (in_ready),
	.req_ready (req_ready),
	.req       (req),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_field (out_field),
	.level     (level)
);

`default_nettype wire

//--- bench/bit_unpacker_tb.sv
/*
 * Testbench of the bit-stream unpacker. Random words and requests are checked
 * against a bit-queue model, then fill, enable and flush behavior is exercised.
 */
`timescale 1ns/1ps
`default_nettype none

`include "unpack_defines.svh"

module bit_unpacker_tb;

	localparam int max_fill = `UNPACK_WORDS * `UNPACK_WORD_W - `UNPACK_WORD_W;

	logic                      clk;
	logic                      rst;
	logic                      in_valid;
	unpack_pkg::word_t         in_data;
	logic                      in_ready;
	logic                      req_valid;
	unpack_pkg::field_req_t    req;
	logic                      req_ready;
	logic                      out_valid;
	unpack_pkg::field_t        out_field;
	logic                      out_ready;
	unpack_pkg::reg_req_t      reg_req;
	unpack_pkg::reg_word_u     reg_rdata;

	// Reference model state
	bit                        bits[$];
	unpack_pkg::field_t        exp_q[$];
	bit                        msb_mode;
	int                        words_in;
	int                        bits_out;
	int                        n_out;

	int                        errors;
	int                        checks;
	int                        timeouts;
	int                        tests;

	bit_unpacker i_dut (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_ready  (in_ready),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.out_valid (out_valid),
		.out_field (out_field),
		.out_ready (out_ready),
		.reg_req   (reg_req),
		.reg_rdata (reg_rdata)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Model and output checks, sampled mid-cycle
	//////////////////////////////////////////////////

	always @(negedge clk)
	begin : monitor
		unpack_pkg::field_t exp_f;
		if (!rst)
		begin
			if (reg_req.we && !reg_req.addr && reg_req.wdata.ctrl_view.flush)
			begin
				bits.delete();
				words_in = 0;
				bits_out = 0;
			end
			if (in_valid && in_ready)
			begin
				for (int i = 0; i < 32; i++)
					bits.push_back(in_data[i]);
				words_in++;
			end
			if (req_valid && req_ready)
			begin
				exp_f = '0;
				exp_f.len = req.len;
				for (int i = 0; i < int'(req.len); i++)
				begin
					if (bits.size() == 0)
					begin
						$display("Model ran out of stream bits at %0t", $time);
						errors++;
					end
					else if (msb_mode)
						exp_f.data[int'(req.len) - 1 - i] = bits.pop_front();
					else
						exp_f.data[i] = bits.pop_front();
				end
				bits_out += int'(req.len);
				exp_q.push_back(exp_f);
			end
			if (out_valid && out_ready)
			begin
				checks++;
				n_out++;
				assert (exp_q.size() > 0)
				else
				begin
					$display("A field was delivered at %0t with no request pending", $time);
					errors++;
				end
				if (exp_q.size() > 0)
				begin
					exp_f = exp_q.pop_front();
					assert (out_field == exp_f)
					else
					begin
						$display("Fail at %0t: field %h len %0d, expected %h len %0d",
							$time, out_field.data, out_field.len, exp_f.data, exp_f.len);
						errors++;
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic check_value(input int got, input int exp, input string what);
		checks++;
		assert (got == exp)
		else
		begin
			$display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic write_reg(input logic addr, input unpack_pkg::reg_word_u data);
		@(posedge clk);
		#1;
		reg_req.we    = 1'b1;
		reg_req.addr  = addr;
		reg_req.wdata = data;
		@(posedge clk);
		#1;
		reg_req.we = 1'b0;
	endtask

	task automatic write_ctrl(input bit enable, input bit msb, input bit flush);
		unpack_pkg::reg_word_u w;
		w = '0;
		w.ctrl_view.enable    = enable;
		w.ctrl_view.msb_first = msb;
		w.ctrl_view.flush     = flush;
		msb_mode = msb;
		write_reg(1'b0, w);
	endtask

	task automatic read_status(output unpack_pkg::status_t s);
		@(posedge clk);
		#1;
		reg_req.addr = 1'b1;
		@(negedge clk);
		s = reg_rdata.status_view;
	endtask

	task automatic report_test(input string name, input int e0);
		tests++;
		$display("Test %s: %0d errors", name, errors - e0);
	endtask

	// Random words and requests until n fields have come out
	task automatic run_stream(input int n, input int ready_pct, input string name);
		int  issued;
		int  start_out;
		int  cycles;
		int  limit;
		bit  in_rdy;
		bit  req_fire;
		issued    = 0;
		start_out = n_out;
		cycles    = 0;
		limit     = n * 20 + 200;
		while ((n_out - start_out < n || in_valid) && cycles < limit)
		begin
			@(negedge clk);
			in_rdy   = in_ready;
			req_fire = req_valid && req_ready;
			@(posedge clk);
			#1;
			// A word only starts when space is known, so it transfers on the next edge
			if (in_valid)
				in_valid = 1'b0;
			else if (in_rdy && issued < n && $urandom_range(0, 3) != 0)
			begin
				in_valid = 1'b1;
				in_data  = $urandom;
			end
			if (req_fire)
				issued++;
			if (req_fire || !req_valid)
			begin
				req_valid = (issued < n) && ($urandom_range(0, 3) != 0);
				req.len   = 4'($urandom_range(0, 15));
			end
			out_ready = ($urandom_range(0, 99) < ready_pct);
			cycles++;
		end
		out_ready = 1'b1;
		if (cycles >= limit)
		begin
			$display("Timeout waiting for %s fields, %0d of %0d delivered",
				name, n_out - start_out, n);
			timeouts++;
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial
	begin : sequence_main
		unpack_pkg::status_t s;
		int e0;
		int cycles;
		bit full;
		void'($urandom(32'h9191d345));
		rst       = 1'b1;
		in_valid  = 1'b0;
		in_data   = '0;
		req_valid = 1'b0;
		req       = '0;
		out_ready = 1'b1;
		reg_req   = '0;
		msb_mode  = 1'b0;
		words_in  = 0;
		bits_out  = 0;
		n_out     = 0;
		errors    = 0;
		checks    = 0;
		timeouts  = 0;
		tests     = 0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;

		e0 = errors;
		@(negedge clk);
		check_value(int'(in_ready), 1, "in_ready after reset");
		check_value(int'(req_ready), 0, "req_ready after reset");
		check_value(int'(out_valid), 0, "out_valid after reset");
		check_value(int'(reg_rdata.ctrl_view.enable), 0, "enable after reset");
		read_status(s);
		check_value(int'(s.level), 0, "level after reset");
		report_test("reset", e0);

		// Long enough for the read pointer to wrap twice
		e0 = errors;
		write_ctrl(1'b1, 1'b0, 1'b0);
		run_stream(600, 100, "lsb_first");
		report_test("lsb_first", e0);

		e0 = errors;
		write_ctrl(1'b1, 1'b1, 1'b0);
		run_stream(300, 100, "msb_first");
		report_test("msb_first", e0);

		e0 = errors;
		write_ctrl(1'b1, 1'b0, 1'b0);
		write_reg(1'b1, '0);
		run_stream(400, 50, "back_pressure");
		read_status(s);
		check_value(int'(s.count), 400, "delivered-field count");
		report_test("back_pressure", e0);

		// Requests off, push single words until the store refuses
		e0 = errors;
		write_ctrl(1'b0, 1'b0, 1'b0);
		cycles = 0;
		full   = 1'b0;
		while (!full && cycles < 200)
		begin
			@(negedge clk);
			if (!in_ready)
				full = 1'b1;
			else
			begin
				@(posedge clk);
				#1;
				in_valid = 1'b1;
				in_data  = $urandom;
				@(posedge clk);
				#1;
				in_valid = 1'b0;
			end
			cycles++;
		end
		if (!full)
		begin
			$display("Timeout waiting for in_ready to fall while filling the store");
			timeouts++;
		end
		read_status(s);
		checks++;
		assert (int'(s.level) > max_fill)
		else
		begin
			$display("Fail at %0t: full level %0d is not above %0d", $time, s.level, max_fill);
			errors++;
		end
		check_value(int'(s.level), words_in * 32 - bits_out, "fill level");
		report_test("fill", e0);

		// Pending request must stay blocked while disabled
		e0 = errors;
		@(posedge clk);
		#1;
		req_valid = 1'b1;
		req.len   = 4'd5;
		repeat (40)
		begin
			@(negedge clk);
			checks++;
			assert (!req_ready)
			else
			begin
				$display("Fail at %0t: req_ready rose with enable clear", $time);
				errors++;
			end
		end
		write_ctrl(1'b0, 1'b0, 1'b1);
		read_status(s);
		check_value(int'(s.level), 0, "level after flush");
		write_ctrl(1'b1, 1'b0, 1'b0);
		run_stream(100, 100, "enable_flush");
		report_test("enable_flush", e0);

		if (exp_q.size() != 0)
		begin
			$display("%0d requested fields were never delivered", exp_q.size());
			errors++;
		end
		$display("Tests run: %0d, checks: %0d, errors: %0d, timeouts: %0d",
			tests, checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
		begin
			$display("Simulation passed");
		end
		else
		begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
rtl/unpack_pkg.sv
rtl/bit_buffer.sv
rtl/field_align.sv
rtl/unpack_regs.sv
rtl/bit_unpacker.sv
bench/bit_unpacker_properties.sv
bench/bit_unpacker_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the unpacker testbench with Verilator and runs it.
# Exits non-zero unless the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f --top-module bit_unpacker_tb -o sim_unpack
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_unpack 2>&1)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
	echo "Simulation run returned status $rc"
	exit 1
fi

if echo "$out" | grep -q "^Simulation passed$"; then
	exit 0
fi
exit 1
